//--- logic/vlsu_pkg.sv
/*
 * Vector load/store address generation package
 * Bus widths, operation and element-width encodings, and the
 * request, AXI address beat and burst command structures
 */
package vlsu_pkg;

  // Bus and field widths
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned AxiDataBytes = 8;
  localparam int unsigned AxiSizeLog   = 3;
  localparam int unsigned VlWidth      = 16;

  // AXI burst limits
  localparam int unsigned PageBytes    = 4096;
  localparam int unsigned MaxBeats     = 256;
  localparam logic [1:0]  AxiBurstIncr = 2'b01;

  // Instruction ids tracked by the stage
  localparam int unsigned NrVInsn      = 8;

  // Command queue sizing
  localparam int unsigned CmdQueueDepth = 4;
  localparam int unsigned CmdPtrWidth   = $clog2(CmdQueueDepth);

  // Element width, log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Vector memory operations, only unit-stride is executed
  typedef enum logic [2:0] {
    OP_VLE  = 3'd0,
    OP_VSE  = 3'd1,
    OP_VLSE = 3'd2,
    OP_VSSE = 3'd3,
    OP_VLXE = 3'd4,
    OP_VSXE = 3'd5
  } mem_op_e;

  // Request from the sequencer
  typedef struct packed {
    logic [2:0]           id;
    mem_op_e              op;
    logic [AddrWidth-1:0] addr;
    logic [VlWidth-1:0]   vl;
    vew_e                 vew;
  } pe_req_t;

  // One AXI address beat, shared by AR and AW
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic [1:0]           burst;
  } axi_ax_t;

  // Burst command for the load/store data units
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic [7:0]           len;
    logic [2:0]           size;
    logic                 is_load;
  } lsu_cmd_t;

endpackage

//--- logic/addrgen_req_if.sv
/*
 * Address generation request channel
 * Carries one accepted unit-stride request from the control FSM
 * to the burst splitter, and the completion pulse back
 */
`timescale 1ns/10ps

interface addrgen_req_if;

  // Request held stable by the control side until done
  logic                                   valid;
  logic [vlsu_pkg::AddrWidth-1:0]         addr;
  logic [vlsu_pkg::VlWidth-1:0]           vl;
  vlsu_pkg::vew_e                         vew;
  logic                                   is_load;

  // Pulses in the cycle the last burst goes out
  logic                                   done;

  modport ctrl (output valid, addr, vl, vew, is_load, input done);
  modport split (input valid, addr, vl, vew, is_load, output done);

endinterface

//--- logic/addrgen_ctrl.sv
/*
 * Address generation control
 * Accepts sequencer requests, tracks running ids, checks op and
 * alignment, hands valid requests to the splitter and acks them
 */
`timescale 1ns/10ps

module addrgen_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  vlsu_pkg::pe_req_t              pe_req_i,
  input  logic                           pe_req_valid_i,
  input  logic [vlsu_pkg::NrVInsn-1:0]   vinsn_running_i,
  output logic                           addrgen_ack_o,
  output logic                           addrgen_error_o,
  addrgen_req_if.ctrl                    req
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_ACK
  } state_e;

  state_e                         state_q, state_d;
  logic                           err_q, err_d;
  logic [vlsu_pkg::NrVInsn-1:0]   running_q, running_d;
  logic                           accept;
  logic                           misaligned;
  logic                           unsupported;

  // Latched request payload
  logic [vlsu_pkg::AddrWidth-1:0] addr_q;
  logic [vlsu_pkg::VlWidth-1:0]   vl_q;
  vlsu_pkg::vew_e                 vew_q;
  logic                           is_load_q;

  // New instruction only when idle and its id is free
  assign accept = (state_q == ST_IDLE) && pe_req_valid_i && !running_q[pe_req_i.id];

  // Base address bits below the element byte count must be zero
  assign misaligned = |(pe_req_i.addr &
                        ((vlsu_pkg::AddrWidth'(1) << pe_req_i.vew) - vlsu_pkg::AddrWidth'(1)));

  // Strided and indexed ops are rejected
  assign unsupported = !(pe_req_i.op inside {vlsu_pkg::OP_VLE, vlsu_pkg::OP_VSE});

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    // Drop ids the sequencer has retired
    running_d = running_q & vinsn_running_i;

    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          running_d[pe_req_i.id] = 1'b1;
          if (misaligned || unsupported) begin
            // Error ack, no burst
            err_d   = 1'b1;
            state_d = ST_ACK;
          end else if (pe_req_i.vl == '0) begin
            // Empty vector, nothing to fetch
            err_d   = 1'b0;
            state_d = ST_ACK;
          end else begin
            err_d   = 1'b0;
            state_d = ST_ISSUE;
          end
        end
      end
      // Wait for the splitter to issue the last burst
      ST_ISSUE: begin
        if (req.done) begin
          state_d = ST_ACK;
        end
      end
      ST_ACK: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      err_q     <= 1'b0;
      running_q <= '0;
    end else begin
      state_q   <= state_d;
      err_q     <= err_d;
      running_q <= running_d;
    end
  end

  // Capture the request on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q    <= pe_req_i.addr;
      vl_q      <= pe_req_i.vl;
      vew_q     <= pe_req_i.vew;
      is_load_q <= (pe_req_i.op == vlsu_pkg::OP_VLE);
    end
  end

  // Request stays up for the whole issue phase
  assign req.valid   = (state_q == ST_ISSUE);
  assign req.addr    = addr_q;
  assign req.vl      = vl_q;
  assign req.vew     = vew_q;
  assign req.is_load = is_load_q;

  // One-cycle ack, error only with it
  assign addrgen_ack_o   = (state_q == ST_ACK);
  assign addrgen_error_o = (state_q == ST_ACK) && err_q;

endmodule

//--- logic/burst_splitter.sv
/*
 * Burst splitter
 * Cuts a unit-stride access into page-bounded AXI INCR bursts of at
 * most MaxBeats beats, drives AR or AW and pushes a matching command
 */
`timescale 1ns/10ps

module burst_splitter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  addrgen_req_if.split         req,
  output vlsu_pkg::axi_ax_t    axi_ar_o,
  output logic                 axi_ar_valid_o,
  input  logic                 axi_ar_ready_i,
  output vlsu_pkg::axi_ax_t    axi_aw_o,
  output logic                 axi_aw_valid_o,
  input  logic                 axi_aw_ready_i,
  output vlsu_pkg::lsu_cmd_t   cmd_o,
  output logic                 cmd_push_o,
  input  logic                 cmd_full_i
);

  logic                           busy_q;
  logic                           latch;
  logic                           fire;
  logic                           done;
  logic                           ax_valid;
  logic                           ax_ready;

  // Current position in the access
  logic [vlsu_pkg::AddrWidth-1:0] addr_q;
  logic [vlsu_pkg::VlWidth-1:0]   rem_q;
  logic [vlsu_pkg::VlWidth-1:0]   rem_next;
  vlsu_pkg::vew_e                 vew_q;
  logic                           is_load_q;

  // Burst geometry
  logic [vlsu_pkg::AddrWidth-1:0] start_addr;
  logic [vlsu_pkg::AddrWidth-1:0] last_byte;
  logic [vlsu_pkg::AddrWidth-1:0] end_addr;
  logic [vlsu_pkg::AddrWidth-1:0] page_last;
  logic [vlsu_pkg::AddrWidth-1:0] page_beats;
  logic [vlsu_pkg::AddrWidth-1:0] span_beats;
  logic [vlsu_pkg::AddrWidth-1:0] beats;
  logic [vlsu_pkg::AddrWidth-1:0] burst_end;
  logic [vlsu_pkg::AddrWidth-1:0] elems_cov;
  vlsu_pkg::axi_ax_t              ax_beat;

  always_comb begin
    // Start on a beat boundary
    start_addr = addr_q & ~vlsu_pkg::AddrWidth'(vlsu_pkg::AxiDataBytes - 1);
    // Last byte of what is left rounded up to a beat end
    last_byte  = addr_q + (vlsu_pkg::AddrWidth'(rem_q) << vew_q) - vlsu_pkg::AddrWidth'(1);
    end_addr   = last_byte | vlsu_pkg::AddrWidth'(vlsu_pkg::AxiDataBytes - 1);
    // No burst leaves the current page
    page_last  = start_addr | vlsu_pkg::AddrWidth'(vlsu_pkg::PageBytes - 1);
    if (end_addr > page_last) begin
      end_addr = page_last;
    end

    page_beats = ((page_last - start_addr) >> vlsu_pkg::AxiSizeLog) + 1;
    span_beats = ((end_addr - start_addr) >> vlsu_pkg::AxiSizeLog) + 1;

    // Smallest of the three limits
    beats = vlsu_pkg::AddrWidth'(vlsu_pkg::MaxBeats);
    if (page_beats < beats) begin
      beats = page_beats;
    end
    if (span_beats < beats) begin
      beats = span_beats;
    end

    // Real end of this burst which may fall short of end_addr at 256 beats
    burst_end = start_addr + (beats << vlsu_pkg::AxiSizeLog) - vlsu_pkg::AddrWidth'(1);

    // Elements covered rounded up
    elems_cov = ((burst_end - addr_q + vlsu_pkg::AddrWidth'(1)) +
                 ((vlsu_pkg::AddrWidth'(1) << vew_q) - vlsu_pkg::AddrWidth'(1))) >> vew_q;

    // Saturate the remaining count at zero
    if (vlsu_pkg::AddrWidth'(rem_q) > elems_cov) begin
      rem_next = rem_q - vlsu_pkg::VlWidth'(elems_cov);
    end else begin
      rem_next = '0;
    end
  end

  // Beat is offered while a burst is pending and the queue has room
  assign ax_valid = busy_q && !cmd_full_i;
  assign ax_ready = is_load_q ? axi_ar_ready_i : axi_aw_ready_i;
  // Transfer needs ready on the selected channel
  assign fire     = ax_valid && ax_ready;
  assign done     = fire && (rem_next == '0);
  assign latch    = !busy_q && req.valid;

  assign ax_beat.addr  = addr_q;
  assign ax_beat.len   = 8'(beats - vlsu_pkg::AddrWidth'(1));
  assign ax_beat.size  = 3'(vlsu_pkg::AxiSizeLog);
  assign ax_beat.burst = vlsu_pkg::AxiBurstIncr;

  assign axi_ar_o       = ax_beat;
  assign axi_aw_o       = ax_beat;
  assign axi_ar_valid_o = ax_valid && is_load_q;
  assign axi_aw_valid_o = ax_valid && !is_load_q;

  // Command mirrors the address beat
  assign cmd_o.addr    = ax_beat.addr;
  assign cmd_o.len     = ax_beat.len;
  assign cmd_o.size    = ax_beat.size;
  assign cmd_o.is_load = is_load_q;
  assign cmd_push_o    = fire;

  assign req.done = done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (latch) begin
      busy_q <= 1'b1;
    end else if (done) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch) begin
      addr_q    <= req.addr;
      rem_q     <= req.vl;
      vew_q     <= req.vew;
      is_load_q <= req.is_load;
    end else if (fire) begin
      // Next burst starts right after this one
      addr_q <= burst_end + vlsu_pkg::AddrWidth'(1);
      rem_q  <= rem_next;
    end
  end

endmodule

//--- logic/lsu_cmd_queue.sv
/*
 * Load/store command queue
 * Small circular FIFO of burst commands for the data units
 */
`timescale 1ns/10ps

module lsu_cmd_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  vlsu_pkg::lsu_cmd_t   cmd_i,
  input  logic                 push_i,
  output logic                 full_o,
  output vlsu_pkg::lsu_cmd_t   cmd_o,
  output logic                 valid_o,
  input  logic                 ldu_ready_i,
  input  logic                 stu_ready_i
);

  vlsu_pkg::lsu_cmd_t               mem_q [vlsu_pkg::CmdQueueDepth];
  logic [vlsu_pkg::CmdPtrWidth-1:0] wr_ptr_q;
  logic [vlsu_pkg::CmdPtrWidth-1:0] rd_ptr_q;
  logic [vlsu_pkg::CmdPtrWidth:0]   count_q;
  logic                             empty;
  logic                             push_en;
  logic                             pop_en;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == (vlsu_pkg::CmdPtrWidth + 1)'(vlsu_pkg::CmdQueueDepth));

  // Writes into a full queue are dropped
  assign push_en = push_i && !full_o;
  // Either data unit can take the head
  assign pop_en  = !empty && (ldu_ready_i || stu_ready_i);

  assign valid_o = !empty;
  assign cmd_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap, depth is a power of two
      if (push_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

endmodule

//--- logic/addrgen_top.sv
/*
 * Vector load/store address generation stage
 * Control FSM, burst splitter and command queue behind plain ports
 */
`timescale 1ns/10ps

module addrgen_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Sequencer
  input  vlsu_pkg::pe_req_t              pe_req_i,
  input  logic                           pe_req_valid_i,
  input  logic [vlsu_pkg::NrVInsn-1:0]   vinsn_running_i,
  output logic                           addrgen_ack_o,
  output logic                           addrgen_error_o,
  // AXI read address
  output vlsu_pkg::axi_ax_t              axi_ar_o,
  output logic                           axi_ar_valid_o,
  input  logic                           axi_ar_ready_i,
  // AXI write address
  output vlsu_pkg::axi_ax_t              axi_aw_o,
  output logic                           axi_aw_valid_o,
  input  logic                           axi_aw_ready_i,
  // Load/store unit commands
  output vlsu_pkg::lsu_cmd_t             lsu_cmd_o,
  output logic                           lsu_cmd_valid_o,
  input  logic                           ldu_ready_i,
  input  logic                           stu_ready_i
);

  // Splitter to queue
  vlsu_pkg::lsu_cmd_t cmd;
  logic               cmd_push;
  logic               cmd_full;

  addrgen_req_if req_if ();

  addrgen_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .vinsn_running_i (vinsn_running_i),
    .addrgen_ack_o   (addrgen_ack_o),
    .addrgen_error_o (addrgen_error_o),
    .req             (req_if.ctrl)
  );

  burst_splitter u_splitter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req            (req_if.split),
    .axi_ar_o       (axi_ar_o),
    .axi_ar_valid_o (axi_ar_valid_o),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_aw_o       (axi_aw_o),
    .axi_aw_valid_o (axi_aw_valid_o),
    .axi_aw_ready_i (axi_aw_ready_i),
    .cmd_o          (cmd),
    .cmd_push_o     (cmd_push),
    .cmd_full_i     (cmd_full)
  );

  lsu_cmd_queue u_cmd_queue (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd),
    .push_i      (cmd_push),
    .full_o      (cmd_full),
    .cmd_o       (lsu_cmd_o),
    .valid_o     (lsu_cmd_valid_o),
    .ldu_ready_i (ldu_ready_i),
    .stu_ready_i (stu_ready_i)
  );

endmodule

//--- verification/addrgen_sva.sv
/*
 * Address generation protocol assertions
 * AR/AW exclusivity, beat stability under back-pressure, ack rules
 */
`timescale 1ns/10ps

module addrgen_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                req_valid_i,
  input logic                ack_i,
  input logic                error_i,
  input vlsu_pkg::axi_ax_t   ar_i,
  input logic                ar_valid_i,
  input logic                ar_ready_i,
  input vlsu_pkg::axi_ax_t   aw_i,
  input logic                aw_valid_i,
  input logic                aw_ready_i
);

  // Only one instruction is in flight so never both channels
  ar_aw_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_i && aw_valid_i))
    else $error("AR and AW valid high in the same cycle");

  // Offered beat holds until taken
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ar_valid_i && !ar_ready_i) |=> (ar_valid_i && $stable(ar_i)))
    else $error("AR beat changed while ready was low");

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (aw_valid_i && !aw_ready_i) |=> (aw_valid_i && $stable(aw_i)))
    else $error("AW beat changed while ready was low");

  // Ack and error only while the sequencer presents a request
  ack_has_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_i || error_i) |-> $past(req_valid_i))
    else $error("Ack or error without a pending request");

endmodule

bind addrgen_top addrgen_sva u_sva (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_valid_i (pe_req_valid_i),
  .ack_i       (addrgen_ack_o),
  .error_i     (addrgen_error_o),
  .ar_i        (axi_ar_o),
  .ar_valid_i  (axi_ar_valid_o),
  .ar_ready_i  (axi_ar_ready_i),
  .aw_i        (axi_aw_o),
  .aw_valid_i  (axi_aw_valid_o),
  .aw_ready_i  (axi_aw_ready_i)
);

//--- verification/tb_addrgen.sv
/*
 * Address generation stage testbench
 * Table of vector memory instructions, reference burst model,
 * AR/AW and command monitors, random stalls and a watchdog
 */
`timescale 1ns/10ps

module tb_addrgen;

  typedef struct packed {
    vlsu_pkg::mem_op_e              op;
    logic [2:0]                     id;
    logic [vlsu_pkg::AddrWidth-1:0] addr;
    logic [vlsu_pkg::VlWidth-1:0]   vl;
    vlsu_pkg::vew_e                 vew;
    logic                           stall;
    logic                           err;
    logic                           blocked;
  } test_t;

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  vlsu_pkg::pe_req_t              pe_req_i;
  logic                           pe_req_valid_i;
  logic [vlsu_pkg::NrVInsn-1:0]   vinsn_running_i;
  logic                           addrgen_ack_o;
  logic                           addrgen_error_o;
  vlsu_pkg::axi_ax_t              axi_ar_o;
  logic                           axi_ar_valid_o;
  logic                           axi_ar_ready_i = 1'b1;
  vlsu_pkg::axi_ax_t              axi_aw_o;
  logic                           axi_aw_valid_o;
  logic                           axi_aw_ready_i = 1'b1;
  vlsu_pkg::lsu_cmd_t             lsu_cmd_o;
  logic                           lsu_cmd_valid_o;
  logic                           ldu_ready_i = 1'b1;
  logic                           stu_ready_i = 1'b1;

  // Table, expected bursts and captured traffic
  test_t                          tests[$];
  string                          names[$];
  vlsu_pkg::axi_ax_t              exp_ax[$];
  vlsu_pkg::lsu_cmd_t             exp_cmd[$];
  vlsu_pkg::axi_ax_t              got_ar[$];
  vlsu_pkg::axi_ax_t              got_aw[$];
  vlsu_pkg::lsu_cmd_t             got_cmd[$];
  logic                           stall_en;
  integer                         seed;
  logic [31:0]                    rnd;
  int                             wd_cycles;

  addrgen_top u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .pe_req_i        (pe_req_i),
    .pe_req_valid_i  (pe_req_valid_i),
    .vinsn_running_i (vinsn_running_i),
    .addrgen_ack_o   (addrgen_ack_o),
    .addrgen_error_o (addrgen_error_o),
    .axi_ar_o        (axi_ar_o),
    .axi_ar_valid_o  (axi_ar_valid_o),
    .axi_ar_ready_i  (axi_ar_ready_i),
    .axi_aw_o        (axi_aw_o),
    .axi_aw_valid_o  (axi_aw_valid_o),
    .axi_aw_ready_i  (axi_aw_ready_i),
    .lsu_cmd_o       (lsu_cmd_o),
    .lsu_cmd_valid_o (lsu_cmd_valid_o),
    .ldu_ready_i     (ldu_ready_i),
    .stu_ready_i     (stu_ready_i)
  );

  always #20 clk_i = ~clk_i;

  // Ready lines change on the falling edge only
  always @(negedge clk_i) begin
    if (stall_en) begin
      rnd            = $random(seed);
      axi_ar_ready_i = rnd[0];
      axi_aw_ready_i = rnd[1];
      // Data units mostly busy so the queue fills up
      ldu_ready_i    = (rnd[3:2] == 2'b00);
      stu_ready_i    = 1'b0;
    end else begin
      axi_ar_ready_i = 1'b1;
      axi_aw_ready_i = 1'b1;
      ldu_ready_i    = 1'b1;
      stu_ready_i    = 1'b1;
    end
  end

  // Monitors on the address channels and the queue head
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (axi_ar_valid_o && axi_ar_ready_i) begin
        got_ar.push_back(axi_ar_o);
      end
      if (axi_aw_valid_o && axi_aw_ready_i) begin
        got_aw.push_back(axi_aw_o);
      end
      if (lsu_cmd_valid_o && (ldu_ready_i || stu_ready_i)) begin
        got_cmd.push_back(lsu_cmd_o);
      end
    end
  end

  task automatic fail_run();
    $display("TB FAILED");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_ax(input string name, input int idx,
                          input vlsu_pkg::axi_ax_t exp, input vlsu_pkg::axi_ax_t act);
    if (act !== exp) begin
      $display("Error: %s beat %0d expected addr=%h len=%0d size=%0d burst=%0d",
               name, idx, exp.addr, exp.len, exp.size, exp.burst);
      $display("Error: %s beat %0d actual addr=%h len=%0d size=%0d burst=%0d",
               name, idx, act.addr, act.len, act.size, act.burst);
      fail_run();
    end
  endtask

  task automatic check_cmd(input string name, input int idx,
                           input vlsu_pkg::lsu_cmd_t exp, input vlsu_pkg::lsu_cmd_t act);
    if (act !== exp) begin
      $display("Error: %s command %0d expected addr=%h len=%0d size=%0d load=%0b",
               name, idx, exp.addr, exp.len, exp.size, exp.is_load);
      $display("Error: %s command %0d actual addr=%h len=%0d size=%0d load=%0b",
               name, idx, act.addr, act.len, act.size, act.is_load);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s error flag expected %0b actual %0b", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp, input int act);
    if (act != exp) begin
      $display("Error: %s %s expected %0d actual %0d", name, what, exp, act);
      fail_run();
    end
  endtask

  task automatic add_test(input string name, input vlsu_pkg::mem_op_e op, input logic [2:0] id,
                          input logic [31:0] addr, input logic [15:0] vl,
                          input vlsu_pkg::vew_e vew, input logic stall, input logic err,
                          input logic blocked);
    test_t t;
    t.op      = op;
    t.id      = id;
    t.addr    = addr;
    t.vl      = vl;
    t.vew     = vew;
    t.stall   = stall;
    t.err     = err;
    t.blocked = blocked;
    tests.push_back(t);
    names.push_back(name);
  endtask

  // Reference split into page-bounded INCR bursts of at most 256 beats
  task automatic build_bursts(input test_t t);
    longint             cur;
    longint             rem;
    longint             ebytes;
    longint             start;
    longint             stop;
    longint             page_end;
    longint             beats;
    longint             bend;
    longint             covered;
    vlsu_pkg::axi_ax_t  ax;
    vlsu_pkg::lsu_cmd_t cmd;
    cur    = t.addr;
    rem    = t.vl;
    ebytes = longint'(1) << t.vew;
    while (rem > 0) begin
      start    = cur - (cur % vlsu_pkg::AxiDataBytes);
      // Last byte left rounded up to the end of its beat
      stop     = ((cur + rem * ebytes - 1) / 8) * 8 + 7;
      page_end = (start / vlsu_pkg::PageBytes) * vlsu_pkg::PageBytes + vlsu_pkg::PageBytes - 1;
      if (stop > page_end) begin
        stop = page_end;
      end
      beats = (stop - start) / 8 + 1;
      if (beats > vlsu_pkg::MaxBeats) begin
        beats = vlsu_pkg::MaxBeats;
      end
      bend = start + beats * 8 - 1;
      // Beat carries the first element byte rather than the aligned start
      ax.addr      = 32'(cur);
      ax.len       = 8'(beats - 1);
      ax.size      = 3'd3;
      ax.burst     = 2'b01;
      cmd.addr     = ax.addr;
      cmd.len      = ax.len;
      cmd.size     = ax.size;
      cmd.is_load  = (t.op == vlsu_pkg::OP_VLE);
      exp_ax.push_back(ax);
      exp_cmd.push_back(cmd);
      covered = (bend - cur + ebytes) / ebytes;
      rem     = (rem > covered) ? rem - covered : 0;
      cur     = bend + 1;
    end
  endtask

  task automatic run_test(input string name, input test_t t, input bit retire);
    vlsu_pkg::axi_ax_t got[$];
    int                other;
    logic              err_seen;
    exp_ax.delete();
    exp_cmd.delete();
    if (!t.err) begin
      build_bursts(t);
    end
    @(posedge clk_i);
    stall_en = t.stall;
    @(negedge clk_i);
    got_ar.delete();
    got_aw.delete();
    got_cmd.delete();
    pe_req_i.id    = t.id;
    pe_req_i.op    = t.op;
    pe_req_i.addr  = t.addr;
    pe_req_i.vl    = t.vl;
    pe_req_i.vew   = t.vew;
    pe_req_valid_i = 1'b1;
    vinsn_running_i[t.id] = 1'b1;
    if (t.blocked) begin
      // Id still running from the previous entry
      repeat (8) begin
        @(posedge clk_i);
        if (addrgen_ack_o) begin
          $display("Error: %s was acknowledged while its id was still running", name);
          fail_run();
        end
      end
      check_count(name, "beats while blocked", 0, got_ar.size() + got_aw.size());
      @(negedge clk_i);
      vinsn_running_i[t.id] = 1'b0;
    end
    @(posedge clk_i);
    while (!addrgen_ack_o) begin
      @(posedge clk_i);
    end
    err_seen = addrgen_error_o;
    @(negedge clk_i);
    pe_req_valid_i = 1'b0;
    if (retire) begin
      vinsn_running_i[t.id] = 1'b0;
    end
    // Drain the command queue
    while (lsu_cmd_valid_o) begin
      @(posedge clk_i);
      @(negedge clk_i);
    end
    check_flag(name, t.err, err_seen);
    if (t.op == vlsu_pkg::OP_VLE) begin
      got   = got_ar;
      other = got_aw.size();
    end else begin
      got   = got_aw;
      other = got_ar.size();
    end
    check_count(name, "address beats", exp_ax.size(), got.size());
    check_count(name, "beats on the other channel", 0, other);
    check_count(name, "commands", exp_cmd.size(), got_cmd.size());
    foreach (exp_ax[i]) begin
      check_ax(name, i, exp_ax[i], got[i]);
    end
    foreach (exp_cmd[i]) begin
      check_cmd(name, i, exp_cmd[i], got_cmd[i]);
    end
  endtask

  task automatic watchdog();
    repeat (wd_cycles) @(posedge clk_i);
    $display("Error: watchdog expired after %0d cycles before the tests finished", wd_cycles);
    $display("TB FAILED");
    $fatal(1, "watchdog timeout");
  endtask

  initial begin
    seed            = 32'hf981a6b8;
    rst_ni          = 1'b0;
    pe_req_i        = '0;
    pe_req_valid_i  = 1'b0;
    vinsn_running_i = '0;
    stall_en        = 1'b0;

    //       name             op                  id    addr       vl     vew  stl err blk
    add_test("ld_short",      vlsu_pkg::OP_VLE,  3'd0, 32'h1000,  16'd16, vlsu_pkg::EW32, 0, 0, 0);
    add_test("st_page_cross", vlsu_pkg::OP_VSE,  3'd1, 32'h2fe0,  16'd16, vlsu_pkg::EW64, 0, 0, 0);
    add_test("ld_long_ew64",  vlsu_pkg::OP_VLE,  3'd2, 32'h10000, 16'd600, vlsu_pkg::EW64, 0, 0, 0);
    add_test("ld_misaligned", vlsu_pkg::OP_VLE,  3'd3, 32'h4002,  16'd8,  vlsu_pkg::EW32, 0, 1, 0);
    add_test("ld_strided",    vlsu_pkg::OP_VLSE, 3'd4, 32'h5000,  16'd8,  vlsu_pkg::EW32, 0, 1, 0);
    add_test("st_stall",      vlsu_pkg::OP_VSE,  3'd5, 32'h7f04,  16'd1000, vlsu_pkg::EW32, 1, 0, 0);
    add_test("ld_stall_ew8",  vlsu_pkg::OP_VLE,  3'd6, 32'ha001,  16'd12000, vlsu_pkg::EW8, 1, 0, 0);
    add_test("ld_held_id",    vlsu_pkg::OP_VLE,  3'd6, 32'hc000,  16'd32, vlsu_pkg::EW16, 0, 0, 1);

    // Budget of four cycles per element plus slack
    wd_cycles = 200;
    foreach (tests[i]) begin
      wd_cycles += int'(tests[i].vl) * 4;
    end
    fork
      watchdog();
    join_none

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Keep the id running when the next entry reuses it
    foreach (tests[i]) begin
      run_test(names[i], tests[i], !((i + 1 < tests.size()) && tests[i + 1].blocked));
    end

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- vlog.f
logic/vlsu_pkg.sv
logic/addrgen_req_if.sv
logic/addrgen_ctrl.sv
logic/burst_splitter.sv
logic/lsu_cmd_queue.sv
logic/addrgen_top.sv
verification/addrgen_sva.sv
verification/tb_addrgen.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_addrgen
FILELIST  := vlog.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
